/* hw/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    // destination register tag and result widths
    localparam int unsigned tag_width = 5;
    localparam int unsigned result_width = 16;
    // ids travel at the widest supported size of 16 slots
    localparam int unsigned id_width = 4;
    // occupancy has to reach a full 16 so it needs one bit more than an id
    localparam int unsigned count_width = id_width + 1;

    typedef logic [tag_width-1:0] tag_t;
    typedef logic [result_width-1:0] result_t;
    typedef logic [id_width-1:0] id_t;
    typedef logic [count_width-1:0] count_t;

    // one rob slot of 23 bits
    typedef struct packed {
        tag_t tag;
        result_t result;
        logic done;
        logic exception;
    } rob_entry_t;

    // dispatch payload
    // the slot is created with done and exception clear
    typedef struct packed {
        tag_t tag;
    } dispatch_t;

    // one completion port with no handshake
    typedef struct packed {
        logic en;
        id_t id;
        result_t result;
        logic exception;
    } complete_t;

    // retire payload in program order
    typedef struct packed {
        id_t id;
        tag_t tag;
        result_t result;
        logic exception;
    } retire_t;

endpackage

`default_nettype wire

/* hw/rob_cfg_pkg.sv */
`default_nettype none

package rob_cfg_pkg;

    // register bus data width
    localparam int unsigned cfg_data_width = 16;
    // retire enable position in the control word
    localparam int unsigned ctrl_retire_en_bit = 0;

    typedef logic [cfg_data_width-1:0] cfg_data_t;

    // configuration opcodes
    typedef enum logic [1:0] {
        cfg_rd_count = 2'd0,
        cfg_rd_retired = 2'd1,
        cfg_wr_ctrl = 2'd2,
        cfg_flush = 2'd3
    } cfg_op_e;

    // request held by the master until ack
    typedef struct packed {
        cfg_op_e op;
        cfg_data_t wdata;
    } cfg_req_t;

    // response valid while ack is high
    typedef struct packed {
        cfg_data_t rdata;
    } cfg_rsp_t;

endpackage

`default_nettype wire

/* hw/fifo_ram.sv */
`default_nettype none

module fifo_ram #(
    parameter int unsigned n_entries = 8,
    parameter int unsigned n_cpl_ports = 2,
    localparam int unsigned ptr_width = $clog2(n_entries)
) (
    input wire clk,
    input wire arst_n,

    // enqueue side
    // enq_addr hands the tail id to dispatch
    input wire enq_valid,
    input wire rob_pkg::rob_entry_t enq_data,
    output logic enq_ready,
    output logic [ptr_width-1:0] enq_addr,

    // dequeue side
    // deq_addr is the head id used at retirement
    input wire deq_ready,
    output logic deq_valid,
    output rob_pkg::rob_entry_t deq_data,
    output logic [ptr_width-1:0] deq_addr,

    // random access ports for the completion path
    input wire [n_cpl_ports-1:0][ptr_width-1:0] rd_addr,
    output rob_pkg::rob_entry_t [n_cpl_ports-1:0] rd_data,
    input wire [n_cpl_ports-1:0] wr_en,
    input wire [n_cpl_ports-1:0][ptr_width-1:0] wr_addr,
    input wire rob_pkg::rob_entry_t [n_cpl_ports-1:0] wr_data,

    input wire flush,
    output rob_pkg::count_t count
);
    // counters carry one extra wrap bit above the pointer
    localparam int unsigned ctr_width = ptr_width + 1;

    logic [ctr_width-1:0] enq_ctr;
    logic [ctr_width-1:0] deq_ctr;
    logic [ptr_width-1:0] enq_ptr;
    logic [ptr_width-1:0] deq_ptr;
    logic ptr_eq;
    logic msb_eq;
    logic empty;
    logic full;
    logic enq;
    logic deq;
    logic [ctr_width-1:0] occupancy;
    rob_pkg::rob_entry_t [n_entries-1:0] slots;

    // pointers are the low bits of the counters
    assign enq_ptr = enq_ctr[ptr_width-1:0];
    assign deq_ptr = deq_ctr[ptr_width-1:0];

    // same slot with the same wrap bit means empty
    // same slot a lap apart means full
    assign ptr_eq = (enq_ptr == deq_ptr);
    assign msb_eq = (enq_ctr[ctr_width-1] == deq_ctr[ctr_width-1]);
    assign empty = ptr_eq && msb_eq;
    assign full = ptr_eq && !msb_eq;

    // a flush wipes every slot at the next edge so nothing is accepted meanwhile
    assign enq_ready = !full && !flush;
    assign deq_valid = !empty;

    // ready/valid transfers
    assign enq = enq_valid && enq_ready;
    assign deq = deq_ready && deq_valid;

    // enqueue and dequeue counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enq_ctr <= '0;
            deq_ctr <= '0;
        end else if (flush) begin
            // full flush restarts both pointers at slot 0
            enq_ctr <= '0;
            deq_ctr <= '0;
        end else begin
            if (enq) begin
                enq_ctr <= enq_ctr + 1'b1;
            end
            if (deq) begin
                deq_ctr <= deq_ctr + 1'b1;
            end
        end
    end

    // slot storage
    for (genvar s = 0; s < n_entries; s++) begin : g_slot
        logic slot_enq;
        logic [n_cpl_ports-1:0] slot_wr;
        rob_pkg::rob_entry_t slot_din;
        rob_pkg::rob_entry_t slot_q;

        // enqueue hits the tail slot only
        assign slot_enq = enq && (enq_ptr == ptr_width'(s));

        // write port hits
        // completions never target the slot being enqueued
        for (genvar p = 0; p < n_cpl_ports; p++) begin : g_hit
            assign slot_wr[p] = wr_en[p] && (wr_addr[p] == ptr_width'(s));
        end

        // ports name distinct ids so at most one select is set
        always_comb begin
            slot_din = enq_data;
            for (int p = 0; p < n_cpl_ports; p++) begin
                if (slot_wr[p]) begin
                    slot_din = wr_data[p];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (flush) begin
                slot_q <= '0;
            end else if (slot_enq || (|slot_wr)) begin
                slot_q <= slot_din;
            end
        end

        assign slots[s] = slot_q;
    end

    // head entry for the retire stage
    assign deq_data = slots[deq_ptr];

    // read ports feed the completion merge
    for (genvar p = 0; p < n_cpl_ports; p++) begin : g_rd
        assign rd_data[p] = slots[rd_addr[p]];
    end

    assign enq_addr = enq_ptr;
    assign deq_addr = deq_ptr;

    // occupancy is the counter distance, modulo the wrap
    assign occupancy = enq_ctr - deq_ctr;
    assign count = rob_pkg::count_t'(occupancy);

endmodule

`default_nettype wire

/* hw/rob_complete.sv */
`default_nettype none

module rob_complete #(
    parameter int unsigned n_entries = 8,
    parameter int unsigned n_cpl_ports = 2,
    localparam int unsigned ptr_width = $clog2(n_entries)
) (
    // completions from the execution units
    input wire rob_pkg::complete_t [n_cpl_ports-1:0] complete,

    // read side of fifo_ram
    input wire rob_pkg::rob_entry_t [n_cpl_ports-1:0] rd_data,
    output logic [n_cpl_ports-1:0][ptr_width-1:0] rd_addr,

    // write side of fifo_ram
    output logic [n_cpl_ports-1:0] wr_en,
    output logic [n_cpl_ports-1:0][ptr_width-1:0] wr_addr,
    output rob_pkg::rob_entry_t [n_cpl_ports-1:0] wr_data
);

    for (genvar p = 0; p < n_cpl_ports; p++) begin : g_port
        logic [ptr_width-1:0] slot_id;
        rob_pkg::rob_entry_t merged;

        // ids arrive at full width and only the slot bits select
        assign slot_id = complete[p].id[ptr_width-1:0];

        // read and write the same slot in one cycle
        assign rd_addr[p] = slot_id;
        assign wr_addr[p] = slot_id;
        assign wr_en[p] = complete[p].en;

        // merge rule
        // the stored tag stays, result and exception come from the unit
        always_comb begin
            merged = rd_data[p];
            merged.result = complete[p].result;
            merged.exception = complete[p].exception;
            merged.done = 1'b1;
        end

        // lands in the slot at the next edge
        assign wr_data[p] = merged;
    end

endmodule

`default_nettype wire

/* hw/rob_retire.sv */
`default_nettype none

module rob_retire #(
    parameter int unsigned n_entries = 8,
    localparam int unsigned ptr_width = $clog2(n_entries)
) (
    input wire clk,
    input wire arst_n,

    // head of the buffer
    input wire rob_pkg::rob_entry_t head,
    input wire head_valid,
    input wire [ptr_width-1:0] head_id,

    // steering from the register block
    input wire retire_en,
    input wire sw_flush,

    // retire port
    input wire retire_ready,
    output logic retire_valid,
    output rob_pkg::retire_t retire,

    // back to fifo_ram and the register block
    output logic deq,
    output logic flush,
    output logic retired
);
    logic fire;
    logic exc_flush;

    // head is retirable once occupied, done and enabled
    // the head does not move while ready is low so valid holds
    assign retire_valid = head_valid && head.done && retire_en;
    assign fire = retire_valid && retire_ready;

    // dequeue on transfer
    assign deq = fire;

    // an excepting entry retires and takes everything younger with it
    assign exc_flush = fire && head.exception;
    assign flush = exc_flush || sw_flush;

    // payload straight from the head slot
    always_comb begin
        retire.id = rob_pkg::id_t'(head_id);
        retire.tag = head.tag;
        retire.result = head.result;
        retire.exception = head.exception;
    end

    // one pulse per transfer
    // the counter update trails the transfer by a cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retired <= 1'b0;
        end else begin
            retired <= fire;
        end
    end

endmodule

`default_nettype wire

/* hw/rob_cfg_regs.sv */
`default_nettype none

module rob_cfg_regs (
    input wire clk,
    input wire arst_n,

    // four-phase register bus
    input wire cfg_req_valid,
    input wire rob_cfg_pkg::cfg_req_t cfg_req,
    output logic cfg_ack,
    output rob_cfg_pkg::cfg_rsp_t cfg_rsp,

    // status in
    input wire rob_pkg::count_t count,
    input wire retired,

    // control out
    output logic retire_en,
    output logic sw_flush
);
    typedef enum logic {
        st_idle,
        st_ack
    } state_e;

    state_e state;
    logic start;
    logic is_flush;
    logic is_wr_ctrl;
    rob_cfg_pkg::cfg_data_t retired_ctr;
    rob_cfg_pkg::cfg_data_t rdata_next;

    // a request acts only when seen from idle
    // so each one executes exactly once
    assign start = (state == st_idle) && cfg_req_valid;
    assign is_flush = (cfg_req.op == rob_cfg_pkg::cfg_flush);
    assign is_wr_ctrl = (cfg_req.op == rob_cfg_pkg::cfg_wr_ctrl);

    // ack is the state itself
    assign cfg_ack = (state == st_ack);

    // handshake FSM
    // ack rises a cycle after req and falls a cycle after req drops
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (cfg_req_valid) begin
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    if (!cfg_req_valid) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // control registers
    // sw_flush is high exactly in the first ack cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_en <= 1'b0;
            sw_flush <= 1'b0;
        end else begin
            sw_flush <= start && is_flush;
            if (start && is_wr_ctrl) begin
                retire_en <= cfg_req.wdata[rob_cfg_pkg::ctrl_retire_en_bit];
            end
        end
    end

    // retired instruction counter, wraps at 16 bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retired_ctr <= '0;
        end else if (retired) begin
            retired_ctr <= retired_ctr + 1'b1;
        end
    end

    // readback select
    always_comb begin
        rdata_next = '0;
        case (cfg_req.op)
            rob_cfg_pkg::cfg_rd_count: rdata_next = rob_cfg_pkg::cfg_data_t'(count);
            rob_cfg_pkg::cfg_rd_retired: rdata_next = retired_ctr;
            // echo of the control bit just written
            rob_cfg_pkg::cfg_wr_ctrl: begin
                rdata_next[rob_cfg_pkg::ctrl_retire_en_bit] =
                    cfg_req.wdata[rob_cfg_pkg::ctrl_retire_en_bit];
            end
            rob_cfg_pkg::cfg_flush: rdata_next = '0;
            default: rdata_next = '0;
        endcase
    end

    // response captured with the action and held through ack
    always_ff @(posedge clk) begin
        if (start) begin
            cfg_rsp.rdata <= rdata_next;
        end
    end

endmodule

`default_nettype wire

/* hw/rob_top.sv */
`default_nettype none

module rob_top #(
    parameter int unsigned n_entries = 8,
    parameter int unsigned n_cpl_ports = 2,
    localparam int unsigned ptr_width = $clog2(n_entries)
) (
    input wire clk,
    input wire arst_n,

    // dispatch
    input wire dispatch_valid,
    input wire rob_pkg::dispatch_t dispatch,
    output logic dispatch_ready,
    output logic [ptr_width-1:0] dispatch_id,

    // completion
    input wire rob_pkg::complete_t [n_cpl_ports-1:0] complete,

    // retire
    output logic retire_valid,
    output rob_pkg::retire_t retire,
    input wire retire_ready,

    // configuration bus
    input wire cfg_req_valid,
    input wire rob_cfg_pkg::cfg_req_t cfg_req,
    output logic cfg_ack,
    output rob_cfg_pkg::cfg_rsp_t cfg_rsp
);
    rob_pkg::rob_entry_t enq_data;
    rob_pkg::rob_entry_t head;
    logic head_valid;
    logic [ptr_width-1:0] head_id;
    logic deq;
    logic flush;
    logic [n_cpl_ports-1:0][ptr_width-1:0] rd_addr;
    rob_pkg::rob_entry_t [n_cpl_ports-1:0] rd_data;
    logic [n_cpl_ports-1:0] wr_en;
    logic [n_cpl_ports-1:0][ptr_width-1:0] wr_addr;
    rob_pkg::rob_entry_t [n_cpl_ports-1:0] wr_data;
    logic retire_en;
    logic sw_flush;
    logic retired;
    rob_pkg::count_t count;

    // ids are carried in a 4-bit field
    if (n_entries < 2 || n_entries > (1 << rob_pkg::id_width) ||
        (n_entries & (n_entries - 1)) != 0) begin : g_bad_depth
        $error("rob_top: n_entries must be a power of two from 2 to 16");
    end

    // new entry holds only the tag, not yet done
    always_comb begin
        enq_data = '0;
        enq_data.tag = dispatch.tag;
    end

    fifo_ram #(
        .n_entries(n_entries),
        .n_cpl_ports(n_cpl_ports)
    ) u_fifo_ram (
        .clk(clk),
        .arst_n(arst_n),
        .enq_valid(dispatch_valid),
        .enq_data(enq_data),
        .enq_ready(dispatch_ready),
        .enq_addr(dispatch_id),
        .deq_ready(deq),
        .deq_valid(head_valid),
        .deq_data(head),
        .deq_addr(head_id),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .flush(flush),
        .count(count)
    );

    rob_complete #(
        .n_entries(n_entries),
        .n_cpl_ports(n_cpl_ports)
    ) u_rob_complete (
        .complete(complete),
        .rd_data(rd_data),
        .rd_addr(rd_addr),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    rob_retire #(
        .n_entries(n_entries)
    ) u_rob_retire (
        .clk(clk),
        .arst_n(arst_n),
        .head(head),
        .head_valid(head_valid),
        .head_id(head_id),
        .retire_en(retire_en),
        .sw_flush(sw_flush),
        .retire_ready(retire_ready),
        .retire_valid(retire_valid),
        .retire(retire),
        .deq(deq),
        .flush(flush),
        .retired(retired)
    );

    rob_cfg_regs u_rob_cfg_regs (
        .clk(clk),
        .arst_n(arst_n),
        .cfg_req_valid(cfg_req_valid),
        .cfg_req(cfg_req),
        .cfg_ack(cfg_ack),
        .cfg_rsp(cfg_rsp),
        .count(count),
        .retired(retired),
        .retire_en(retire_en),
        .sw_flush(sw_flush)
    );

endmodule

`default_nettype wire

/* dv/rob_tb.sv */
`default_nettype none

module rob_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_entries = 8;
    localparam int n_cpl_ports = 2;
    localparam int ptr_width = $clog2(n_entries);

    logic clk;
    logic arst_n;
    logic dispatch_valid;
    rob_pkg::dispatch_t dispatch;
    logic dispatch_ready;
    logic [ptr_width-1:0] dispatch_id;
    rob_pkg::complete_t [n_cpl_ports-1:0] complete;
    logic retire_valid;
    rob_pkg::retire_t retire;
    logic retire_ready;
    logic cfg_req_valid;
    rob_cfg_pkg::cfg_req_t cfg_req;
    logic cfg_ack;
    rob_cfg_pkg::cfg_rsp_t cfg_rsp;

    // model of the slots, indexed by rob id
    rob_pkg::tag_t m_tag [n_entries];
    rob_pkg::result_t m_result [n_entries];
    logic m_done [n_entries];
    logic m_exc [n_entries];
    // live ids in program order, oldest first
    int order [$];
    int m_tail;
    // register block model
    logic m_retire_en;
    logic m_ack;
    logic m_sw_flush;
    logic m_ret_pulse;
    logic [15:0] m_ret_ctr;
    logic [15:0] m_rsp;
    int total_retired;
    int total_dispatched;
    // retire transfers seen on the DUT ports
    int seen_retired;
    // payload that has to hold while retire is stalled
    logic stalled;
    rob_pkg::retire_t stalled_payload;

    string cur_test;
    int errors;
    int errors_at_start;
    int tests_passed;
    int tests_failed;

    rob_top DUT (
        .clk(clk),
        .arst_n(arst_n),
        .dispatch_valid(dispatch_valid),
        .dispatch(dispatch),
        .dispatch_ready(dispatch_ready),
        .dispatch_id(dispatch_id),
        .complete(complete),
        .retire_valid(retire_valid),
        .retire(retire),
        .retire_ready(retire_ready),
        .cfg_req_valid(cfg_req_valid),
        .cfg_req(cfg_req),
        .cfg_ack(cfg_ack),
        .cfg_rsp(cfg_rsp)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout in test %s: %s", cur_test, what);
        $display("Something failed");
        $finish;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s: passed", cur_test);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", cur_test, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic clear_slots();
        for (int i = 0; i < n_entries; i++) begin
            m_tag[i] = '0;
            m_result[i] = '0;
            m_done[i] = 1'b0;
            m_exc[i] = 1'b0;
        end
        order.delete();
        m_tail = 0;
    endtask

    function automatic rob_pkg::complete_t make_completion(input int id, input logic exc);
        rob_pkg::complete_t c;
        c.en = 1'b1;
        c.id = rob_pkg::id_t'(id);
        c.result = rob_pkg::result_t'($urandom);
        c.exception = exc;
        return c;
    endfunction

    // one clock cycle
    // inputs are already driven, outputs are checked against the model,
    // then the model takes the edge and the next falling edge is reached
    task automatic tick();
        int head;
        logic exp_valid;
        logic exp_ready;
        logic ret_fire;
        logic exp_flush;
        logic start;
        int idx;
        rob_pkg::retire_t exp_ret;
        #1;
        // transfers the DUT actually performs
        if (retire_valid && retire_ready) begin
            seen_retired++;
        end
        head = 0;
        if (order.size() > 0) begin
            head = order[0];
        end
        // retire rule: occupied, done and enabled
        exp_valid = (order.size() > 0) && m_done[head] && m_retire_en;
        exp_ret.id = rob_pkg::id_t'(head);
        exp_ret.tag = m_tag[head];
        exp_ret.result = m_result[head];
        exp_ret.exception = m_exc[head];
        check_value("retire_valid", 32'(exp_valid), 32'(retire_valid));
        if (exp_valid) begin
            check_value("retire payload", 32'(exp_ret), 32'(retire));
        end
        // a stalled head must not move or change
        if (stalled) begin
            check_value("held retire_valid", 32'(1), 32'(retire_valid));
            check_value("held retire payload", 32'(stalled_payload), 32'(retire));
        end
        ret_fire = exp_valid && retire_ready;
        exp_flush = (ret_fire && m_exc[head]) || m_sw_flush;
        exp_ready = (order.size() < n_entries) && !exp_flush;
        check_value("dispatch_ready", 32'(exp_ready), 32'(dispatch_ready));
        if (dispatch_valid && exp_ready) begin
            check_value("dispatch_id", 32'(m_tail), 32'(dispatch_id));
        end
        check_value("cfg_ack", 32'(m_ack), 32'(cfg_ack));
        if (m_ack) begin
            check_value("cfg_rsp", 32'(m_rsp), 32'(cfg_rsp.rdata));
        end
        stalled = exp_valid && !retire_ready && !exp_flush;
        stalled_payload = exp_ret;

        // register block acts once, when a request meets an idle responder
        start = !m_ack && cfg_req_valid;
        if (start) begin
            case (cfg_req.op)
                rob_cfg_pkg::cfg_rd_count: m_rsp = 16'(order.size());
                rob_cfg_pkg::cfg_rd_retired: m_rsp = m_ret_ctr;
                rob_cfg_pkg::cfg_wr_ctrl: m_rsp = {15'b0, cfg_req.wdata[0]};
                default: m_rsp = '0;
            endcase
            if (cfg_req.op == rob_cfg_pkg::cfg_wr_ctrl) begin
                m_retire_en = cfg_req.wdata[0];
            end
        end
        m_sw_flush = start && (cfg_req.op == rob_cfg_pkg::cfg_flush);
        m_ack = cfg_req_valid;
        // counter trails the transfer by one cycle
        m_ret_ctr = m_ret_ctr + 16'(m_ret_pulse);
        m_ret_pulse = ret_fire;

        if (ret_fire) begin
            total_retired++;
        end
        if (exp_flush) begin
            clear_slots();
        end else begin
            if (ret_fire) begin
                void'(order.pop_front());
            end
            for (int p = 0; p < n_cpl_ports; p++) begin
                if (complete[p].en) begin
                    idx = int'(complete[p].id);
                    m_result[idx] = complete[p].result;
                    m_exc[idx] = complete[p].exception;
                    m_done[idx] = 1'b1;
                end
            end
            if (dispatch_valid && exp_ready) begin
                m_tag[m_tail] = dispatch.tag;
                m_result[m_tail] = '0;
                m_done[m_tail] = 1'b0;
                m_exc[m_tail] = 1'b0;
                order.push_back(m_tail);
                m_tail = (m_tail + 1) % n_entries;
                total_dispatched++;
            end
        end

        @(negedge clk);
        dispatch_valid = 1'b0;
        complete = '0;
    endtask

    // one four-phase access, the model keeps running meanwhile
    task automatic cfg_access(input rob_cfg_pkg::cfg_op_e op, input logic [15:0] wdata,
                              output logic [15:0] rdata);
        int guard;
        cfg_req.op = op;
        cfg_req.wdata = wdata;
        cfg_req_valid = 1'b1;
        guard = 0;
        tick();
        while (!cfg_ack) begin
            guard++;
            if (guard > 20) begin
                stop_on_timeout("cfg_ack did not rise");
            end
            tick();
        end
        rdata = cfg_rsp.rdata;
        cfg_req_valid = 1'b0;
        guard = 0;
        tick();
        while (cfg_ack) begin
            guard++;
            if (guard > 20) begin
                stop_on_timeout("cfg_ack did not fall");
            end
            tick();
        end
    endtask

    // random dispatch and completions on distinct not yet done ids
    task automatic drive_random(input int ready_pct, input logic allow_dispatch);
        int live [$];
        int pick;
        dispatch_valid = allow_dispatch && 1'($urandom % 2);
        dispatch.tag = rob_pkg::tag_t'($urandom);
        retire_ready = 32'($urandom % 100) < 32'(ready_pct);
        foreach (order[i]) begin
            if (!m_done[order[i]]) begin
                live.push_back(order[i]);
            end
        end
        for (int p = 0; p < n_cpl_ports; p++) begin
            if (live.size() > 0 && ($urandom % 2) == 1) begin
                pick = int'($urandom % 32'(live.size()));
                complete[p] = make_completion(live[pick], 1'b0);
                live.delete(pick);
            end
        end
    endtask

    // dispatch one random tag, retried until taken
    task automatic dispatch_one();
        int guard;
        guard = 0;
        dispatch_valid = 1'b1;
        dispatch.tag = rob_pkg::tag_t'($urandom);
        while (!dispatch_ready) begin
            guard++;
            if (guard > 20) begin
                stop_on_timeout("dispatch was never accepted");
            end
            tick();
            dispatch_valid = 1'b1;
        end
        tick();
    endtask

    initial begin
        logic [15:0] rdata;
        int guard;
        int k;
        int r0;
        int s0;
        int d0;
        int occ0;
        int ids [$];
        void'($urandom(32'h41b));
        clk = 1'b0;
        arst_n = 1'b0;
        dispatch_valid = 1'b0;
        dispatch = '0;
        complete = '0;
        retire_ready = 1'b0;
        cfg_req_valid = 1'b0;
        cfg_req = '0;
        clear_slots();
        m_retire_en = 1'b0;
        m_ack = 1'b0;
        m_sw_flush = 1'b0;
        m_ret_pulse = 1'b0;
        m_ret_ctr = '0;
        m_rsp = '0;
        total_retired = 0;
        total_dispatched = 0;
        seen_retired = 0;
        stalled = 1'b0;
        stalled_payload = '0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // 1: state after reset, nothing retires while disabled
        start_test("reset_state");
        check_value("dispatch_ready after reset", 32'(1), 32'(dispatch_ready));
        check_value("retire_valid after reset", 32'(0), 32'(retire_valid));
        cfg_access(rob_cfg_pkg::cfg_rd_count, '0, rdata);
        check_value("count after reset", 32'(0), 32'(rdata));
        cfg_access(rob_cfg_pkg::cfg_rd_retired, '0, rdata);
        check_value("retired after reset", 32'(0), 32'(rdata));
        for (int i = 0; i < 3; i++) begin
            dispatch_one();
        end
        complete[0] = make_completion(order[0], 1'b0);
        complete[1] = make_completion(order[1], 1'b0);
        tick();
        complete[0] = make_completion(order[2], 1'b0);
        tick();
        retire_ready = 1'b1;
        for (int i = 0; i < 6; i++) begin
            check_value("retire_valid while disabled", 32'(0), 32'(retire_valid));
            tick();
        end
        cfg_access(rob_cfg_pkg::cfg_flush, '0, rdata);
        end_test();

        // 2: ids run in order and the buffer fills
        start_test("dispatch_full");
        k = 0;
        guard = 0;
        while (order.size() < n_entries) begin
            guard++;
            if (guard > 50) begin
                stop_on_timeout("buffer never filled");
            end
            check_value("dispatch id", 32'(k), 32'(dispatch_id));
            dispatch_valid = 1'b1;
            dispatch.tag = rob_pkg::tag_t'($urandom);
            tick();
            k++;
        end
        check_value("dispatch_ready when full", 32'(0), 32'(dispatch_ready));
        // a ninth attempt is refused
        dispatch_valid = 1'b1;
        dispatch.tag = rob_pkg::tag_t'($urandom);
        tick();
        cfg_access(rob_cfg_pkg::cfg_rd_count, '0, rdata);
        check_value("count when full", 32'(n_entries), 32'(rdata));
        end_test();

        // 3: out of order completion, in order retirement
        start_test("in_order_retire");
        cfg_access(rob_cfg_pkg::cfg_wr_ctrl, 16'h0001, rdata);
        r0 = total_retired;
        guard = 0;
        while (total_retired - r0 < 40) begin
            guard++;
            if (guard > 2000) begin
                stop_on_timeout("too few retirements");
            end
            drive_random(100, 1'b1);
            tick();
        end
        end_test();

        // 4: random stalls on the retire port
        start_test("back_pressure");
        r0 = total_retired;
        s0 = seen_retired;
        d0 = total_dispatched;
        occ0 = order.size();
        guard = 0;
        while (total_retired - r0 < 40) begin
            guard++;
            if (guard > 4000) begin
                stop_on_timeout("too few retirements under stalls");
            end
            drive_random(40, 1'b1);
            tick();
        end
        // drain what is left
        guard = 0;
        while (order.size() > 0) begin
            guard++;
            if (guard > 500) begin
                stop_on_timeout("buffer did not drain");
            end
            drive_random(50, 1'b0);
            tick();
        end
        retire_ready = 1'b1;
        check_value("retired versus dispatched", 32'(occ0 + total_dispatched - d0),
                    32'(seen_retired - s0));
        end_test();

        // 5: exception retire flushes the younger entries
        start_test("exception_flush");
        retire_ready = 1'b0;
        for (int i = 0; i < 5; i++) begin
            dispatch_one();
        end
        ids = order;
        complete[0] = make_completion(ids[0], 1'b0);
        complete[1] = make_completion(ids[1], 1'b0);
        tick();
        complete[0] = make_completion(ids[2], 1'b1);
        complete[1] = make_completion(ids[3], 1'b0);
        tick();
        complete[0] = make_completion(ids[4], 1'b0);
        tick();
        s0 = seen_retired;
        retire_ready = 1'b1;
        guard = 0;
        while (order.size() > 0) begin
            guard++;
            if (guard > 50) begin
                stop_on_timeout("exception entry never retired");
            end
            // dispatch in the flush cycle must be refused
            if (m_exc[order[0]]) begin
                dispatch_valid = 1'b1;
                dispatch.tag = rob_pkg::tag_t'($urandom);
            end
            tick();
        end
        check_value("retired up to the exception", 32'(3), 32'(seen_retired - s0));
        for (int i = 0; i < 4; i++) begin
            check_value("retire_valid after flush", 32'(0), 32'(retire_valid));
            tick();
        end
        cfg_access(rob_cfg_pkg::cfg_rd_count, '0, rdata);
        check_value("count after exception", 32'(0), 32'(rdata));
        check_value("id after exception", 32'(0), 32'(dispatch_id));
        dispatch_one();
        end_test();

        // 6: software flush and the retired counter
        start_test("sw_flush_counter");
        cfg_access(rob_cfg_pkg::cfg_wr_ctrl, 16'h0000, rdata);
        for (int i = 0; i < 3; i++) begin
            dispatch_one();
        end
        complete[0] = make_completion(order[1], 1'b0);
        complete[1] = make_completion(order[2], 1'b0);
        tick();
        cfg_access(rob_cfg_pkg::cfg_flush, '0, rdata);
        cfg_access(rob_cfg_pkg::cfg_rd_count, '0, rdata);
        check_value("count after flush", 32'(0), 32'(rdata));
        check_value("id after flush", 32'(0), 32'(dispatch_id));
        cfg_access(rob_cfg_pkg::cfg_rd_retired, '0, rdata);
        check_value("retired count", 32'(total_retired[15:0]), 32'(rdata));
        dispatch_one();
        end_test();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/rob_pkg.sv
hw/rob_cfg_pkg.sv
hw/fifo_ram.sv
hw/rob_complete.sv
hw/rob_retire.sv
hw/rob_cfg_regs.sv
hw/rob_top.sv
dv/rob_tb.sv

/* Makefile */
# reorder buffer simulation with Verilator

SIM = obj_dir/rob_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module rob_tb -o rob_sim

# pass only when the testbench printed its pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
